// ==== design/video_pkg.sv ====
// Video frame definitions

package video_pkg;

    //////////////////////////////
    // Frame geometry
    //////////////////////////////

    // Small test frame, 8 columns by 4 rows
    localparam int frame_width  = 8;
    localparam int frame_height = 4;

    // Pixel position within the frame
    typedef logic [2:0] col_t;
    typedef logic [1:0] row_t;

    // Store address is row * width + column
    typedef logic [4:0] addr_t;

    //////////////////////////////
    // Pixel format
    //////////////////////////////

    // Red in the top byte, then green, then blue
    typedef logic [23:0] pixel_t;

    // Fill colour for lookups outside the source frame
    localparam pixel_t black_pixel = 24'h00_0000;

    //////////////////////////////
    // Output queue
    //////////////////////////////

    localparam int queue_depth = 8;

    // Needs one extra bit to hold a full count
    typedef logic [3:0] queue_count_t;

    // One output beat, pixel plus framing flags
    typedef struct packed {
        pixel_t pixel;
        logic   sof;
        logic   eol;
    } out_beat_t;

endpackage

// ==== design/warp_pkg.sv ====
// Affine warp definitions

package warp_pkg;

    //////////////////////////////
    // Coefficient format
    //////////////////////////////

    // Signed Q8.8
    typedef logic signed [15:0] coef_t;

    // Fraction bits of every fixed-point value below
    localparam int coef_frac_bits = 8;

    // Source x = a*x + b*y + c
    // Source y = d*x + e*y + f
    // c and f are Q8.8 offsets
    typedef struct packed {
        coef_t a;
        coef_t b;
        coef_t c;
        coef_t d;
        coef_t e;
        coef_t f;
    } warp_matrix_t;

    //////////////////////////////
    // Mapping results
    //////////////////////////////

    // Signed Q8.8 sum of the three terms, room for the integer growth
    typedef logic signed [23:0] acc_t;

    // Source coordinate after rounding, signed so that
    // negative positions can be range-checked
    typedef logic signed [15:0] src_coord_t;

endpackage

// ==== design/frame_capture.sv ====
// Source frame capture
`timescale 1ns/10ps

module frame_capture (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  in_valid,
    input  logic                  in_sof,
    input  logic                  in_eol,
    input  video_pkg::pixel_t     in_pixel,
    input  warp_pkg::warp_matrix_t coefs,
    output logic                  wr_en,
    output video_pkg::addr_t      wr_addr,
    output video_pkg::pixel_t     wr_pixel,
    output warp_pkg::warp_matrix_t matrix,
    output logic                  frame_ready
);

    // Position of the next expected beat
    video_pkg::col_t col;
    video_pkg::row_t row;

    // Position of the beat on the bus this cycle
    video_pkg::col_t beat_col;
    video_pkg::row_t beat_row;
    logic            last_beat;

    //////////////////////////////
    // Stream position
    //////////////////////////////

    // Start of frame overrides whatever the counters hold
    assign beat_col = in_sof ? '0 : col;
    assign beat_row = in_sof ? '0 : row;

    assign last_beat = (beat_col == video_pkg::col_t'(video_pkg::frame_width - 1))
                    && (beat_row == video_pkg::row_t'(video_pkg::frame_height - 1));

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            col <= '0;
            row <= '0;
        end else if (in_valid) begin
            if (in_eol) begin
                // Wrap to the start of the next line
                col <= '0;
                row <= beat_row + 1'b1;
            end else begin
                col <= beat_col + 1'b1;
                row <= beat_row;
            end
        end
    end

    //////////////////////////////
    // Store write
    //////////////////////////////

    // Every beat lands in the store on its own clock edge
    assign wr_en    = in_valid;
    assign wr_addr  = video_pkg::addr_t'(beat_row) * video_pkg::addr_t'(video_pkg::frame_width)
                    + video_pkg::addr_t'(beat_col);
    assign wr_pixel = in_pixel;

    // Completion pulse, the cycle after the last pixel is written
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            frame_ready <= 1'b0;
        end else begin
            frame_ready <= in_valid && last_beat;
        end
    end

    // Coefficients for the whole frame come with its first beat
    always_ff @(posedge clock) begin
        if (in_valid && in_sof) begin
            matrix <= coefs;
        end
    end

    // Line ends only ever arrive on the last column
    a_eol_at_last_col: assert property (@(posedge clock) disable iff (reset)
        (in_valid && in_eol) |-> beat_col == video_pkg::col_t'(video_pkg::frame_width - 1));

endmodule

// ==== design/frame_store.sv ====
// Source frame memory
`timescale 1ns/10ps

module frame_store (
    input  logic              clock,
    input  logic              wr_en,
    input  video_pkg::addr_t  wr_addr,
    input  video_pkg::pixel_t wr_pixel,
    input  logic              rd_en,
    input  video_pkg::addr_t  rd_addr,
    output video_pkg::pixel_t rd_pixel
);

    // One pixel per location, raster order
    video_pkg::pixel_t mem [video_pkg::frame_width * video_pkg::frame_height];

    //////////////////////////////
    // Write port
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_pixel;
        end
    end

    //////////////////////////////
    // Read port
    //////////////////////////////

    // Data one cycle after the request
    // Holds its last value while rd_en is low
    always_ff @(posedge clock) begin
        if (rd_en) begin
            rd_pixel <= mem[rd_addr];
        end
    end

endmodule

// ==== design/warp_engine.sv ====
// Affine warp engine
`timescale 1ns/10ps

module warp_engine (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   frame_ready,
    input  warp_pkg::warp_matrix_t matrix,
    output logic                   rd_en,
    output video_pkg::addr_t       rd_addr,
    input  video_pkg::pixel_t      rd_pixel,
    input  video_pkg::queue_count_t count,
    output logic                   push,
    output video_pkg::out_beat_t   push_beat
);

    typedef enum logic {IDLE, WALK} engine_state_t;

    engine_state_t state;

    // Destination raster position
    video_pkg::col_t dest_col;
    video_pkg::row_t dest_row;
    warp_pkg::acc_t  dest_x;
    warp_pkg::acc_t  dest_y;

    logic issue;
    logic last_col;
    logic last_row;
    logic credit_ok;

    video_pkg::queue_count_t in_flight;

    // Stage 1 registers
    logic           s1_valid;
    warp_pkg::acc_t s1_acc_x;
    warp_pkg::acc_t s1_acc_y;
    logic           s1_sof;
    logic           s1_eol;

    // Stage 2 rounding and range check
    warp_pkg::src_coord_t src_x;
    warp_pkg::src_coord_t src_y;
    logic                 src_in_range;

    // Stage 2 registers
    logic s2_valid;
    logic s2_in_range;
    logic s2_sof;
    logic s2_eol;

    //////////////////////////////
    // Raster walker
    //////////////////////////////

    assign last_col = (dest_col == video_pkg::col_t'(video_pkg::frame_width - 1));
    assign last_row = (dest_row == video_pkg::row_t'(video_pkg::frame_height - 1));

    // Every pixel in the pipe will need a queue slot, pushes not yet counted included
    assign in_flight = video_pkg::queue_count_t'(s1_valid)
                     + video_pkg::queue_count_t'(s2_valid)
                     + video_pkg::queue_count_t'(push);
    assign credit_ok = (count + in_flight) < video_pkg::queue_count_t'(video_pkg::queue_depth);

    assign issue = (state == WALK) && credit_ok;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state    <= IDLE;
            dest_col <= '0;
            dest_row <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (frame_ready) begin
                        state    <= WALK;
                        dest_col <= '0;
                        dest_row <= '0;
                    end
                end
                WALK: begin
                    if (issue) begin
                        if (last_col) begin
                            dest_col <= '0;
                            dest_row <= dest_row + 1'b1;
                            // Whole destination frame issued
                            if (last_row) begin
                                state <= IDLE;
                            end
                        end else begin
                            dest_col <= dest_col + 1'b1;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    //////////////////////////////
    // Stage 1, accumulate
    //////////////////////////////

    // Integer positions widened to Q8.8 product width
    assign dest_x = warp_pkg::acc_t'(dest_col);
    assign dest_y = warp_pkg::acc_t'(dest_row);

    always_ff @(posedge clock) begin
        s1_acc_x <= warp_pkg::acc_t'(matrix.a) * dest_x + warp_pkg::acc_t'(matrix.b) * dest_y
                  + warp_pkg::acc_t'(matrix.c);
        s1_acc_y <= warp_pkg::acc_t'(matrix.d) * dest_x + warp_pkg::acc_t'(matrix.e) * dest_y
                  + warp_pkg::acc_t'(matrix.f);
        s1_sof   <= (dest_col == '0) && (dest_row == '0);
        s1_eol   <= last_col;
    end

    //////////////////////////////
    // Stage 2, round and read
    //////////////////////////////

    // Round half up, drop the fraction and add back its top bit
    assign src_x = warp_pkg::src_coord_t'(s1_acc_x >>> warp_pkg::coef_frac_bits)
                 + warp_pkg::src_coord_t'(s1_acc_x[warp_pkg::coef_frac_bits - 1]);
    assign src_y = warp_pkg::src_coord_t'(s1_acc_y >>> warp_pkg::coef_frac_bits)
                 + warp_pkg::src_coord_t'(s1_acc_y[warp_pkg::coef_frac_bits - 1]);

    assign src_in_range = (src_x >= 0) && (src_x < video_pkg::frame_width)
                       && (src_y >= 0) && (src_y < video_pkg::frame_height);

    // Out-of-range pixels skip the store
    assign rd_en   = s1_valid && src_in_range;
    assign rd_addr = video_pkg::addr_t'(src_y) * video_pkg::addr_t'(video_pkg::frame_width)
                   + video_pkg::addr_t'(src_x);

    always_ff @(posedge clock) begin
        s2_in_range <= src_in_range;
        s2_sof      <= s1_sof;
        s2_eol      <= s1_eol;
    end

    //////////////////////////////
    // Stage 3, select and push
    //////////////////////////////

    always_ff @(posedge clock) begin
        push_beat.pixel <= s2_in_range ? rd_pixel : video_pkg::black_pixel;
        push_beat.sof   <= s2_sof;
        push_beat.eol   <= s2_eol;
    end

    // Valid chain, issue to push in three cycles
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            push     <= 1'b0;
        end else begin
            s1_valid <= issue;
            s2_valid <= s1_valid;
            push     <= s2_valid;
        end
    end

    // Store reads only for sums that round into the frame
    // In Q8.8 that is from half a pixel below zero to half a pixel short of the far edge
    a_read_in_range: assert property (@(posedge clock) disable iff (reset)
        rd_en |-> (s1_acc_x >= -(1 << (warp_pkg::coef_frac_bits - 1)))
               && (s1_acc_x < (video_pkg::frame_width << warp_pkg::coef_frac_bits)
                              - (1 << (warp_pkg::coef_frac_bits - 1)))
               && (s1_acc_y >= -(1 << (warp_pkg::coef_frac_bits - 1)))
               && (s1_acc_y < (video_pkg::frame_height << warp_pkg::coef_frac_bits)
                              - (1 << (warp_pkg::coef_frac_bits - 1))));

    // Credit check keeps pushes off a full queue
    a_no_push_when_full: assert property (@(posedge clock) disable iff (reset)
        push |-> count != video_pkg::queue_count_t'(video_pkg::queue_depth));

endmodule

// ==== design/output_queue.sv ====
// Output pixel FIFO
`timescale 1ns/10ps

module output_queue (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    push,
    input  video_pkg::out_beat_t    push_beat,
    output video_pkg::queue_count_t count,
    output video_pkg::out_beat_t    out_beat,
    output logic                    out_valid,
    input  logic                    out_ready
);

    typedef logic [$clog2(video_pkg::queue_depth)-1:0] ptr_t;

    video_pkg::out_beat_t mem [video_pkg::queue_depth];

    ptr_t put_ptr;
    ptr_t get_ptr;
    logic pop;

    //////////////////////////////
    // Output side
    //////////////////////////////

    // Head entry shown directly, stays put until taken
    assign out_valid = (count != '0);
    assign out_beat  = mem[get_ptr];
    assign pop       = out_valid && out_ready;

    //////////////////////////////
    // Storage
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (push) begin
            mem[put_ptr] <= push_beat;
        end
    end

    // Pointers wrap naturally at the queue depth
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            put_ptr <= '0;
            get_ptr <= '0;
            count   <= '0;
        end else begin
            if (push) begin
                put_ptr <= put_ptr + 1'b1;
            end
            if (pop) begin
                get_ptr <= get_ptr + 1'b1;
            end
            // Push and pop together leave the count alone
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Occupancy never wraps past the depth
    // A pop while empty or a push while full would break this
    a_count_in_range: assert property (@(posedge clock) disable iff (reset)
        count <= video_pkg::queue_count_t'(video_pkg::queue_depth));

    // Stalled head beat holds steady
    a_hold_on_stall: assert property (@(posedge clock) disable iff (reset)
        (out_valid && !out_ready) |=> out_valid && $stable(out_beat));

endmodule

// ==== design/keystone_top.sv ====
// Keystone corrector top level
`timescale 1ns/10ps

module keystone_top (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   in_valid,
    input  logic                   in_sof,
    input  logic                   in_eol,
    input  video_pkg::pixel_t      in_pixel,
    input  warp_pkg::warp_matrix_t coefs,
    output video_pkg::out_beat_t   out_beat,
    output logic                   out_valid,
    input  logic                   out_ready
);

    // Capture to store
    logic              wr_en;
    video_pkg::addr_t  wr_addr;
    video_pkg::pixel_t wr_pixel;

    // Capture to engine
    warp_pkg::warp_matrix_t matrix;
    logic                   frame_ready;

    // Engine to store
    logic              rd_en;
    video_pkg::addr_t  rd_addr;
    video_pkg::pixel_t rd_pixel;

    // Engine to queue
    logic                    push;
    video_pkg::out_beat_t    push_beat;
    video_pkg::queue_count_t count;

    //////////////////////////////
    // Producer and buffer
    //////////////////////////////

    frame_capture u_capture (
        .clock       (clock),
        .reset       (reset),
        .in_valid    (in_valid),
        .in_sof      (in_sof),
        .in_eol      (in_eol),
        .in_pixel    (in_pixel),
        .coefs       (coefs),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_pixel    (wr_pixel),
        .matrix      (matrix),
        .frame_ready (frame_ready)
    );

    frame_store u_store (
        .clock    (clock),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_pixel (wr_pixel),
        .rd_en    (rd_en),
        .rd_addr  (rd_addr),
        .rd_pixel (rd_pixel)
    );

    //////////////////////////////
    // Consumer and output
    //////////////////////////////

    warp_engine u_engine (
        .clock       (clock),
        .reset       (reset),
        .frame_ready (frame_ready),
        .matrix      (matrix),
        .rd_en       (rd_en),
        .rd_addr     (rd_addr),
        .rd_pixel    (rd_pixel),
        .count       (count),
        .push        (push),
        .push_beat   (push_beat)
    );

    output_queue u_queue (
        .clock     (clock),
        .reset     (reset),
        .push      (push),
        .push_beat (push_beat),
        .count     (count),
        .out_beat  (out_beat),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

endmodule

// ==== dv/tb_keystone.sv ====
// Keystone corrector testbench
`timescale 1ns/10ps

module tb_keystone;

    // Per case: six coefficients, source frame, expected frame
    localparam int case_words = 70;
    localparam int case_count = 3;
    localparam int frame_size = video_pkg::frame_width * video_pkg::frame_height;

    logic                   clock = 1'b0;
    logic                   reset;
    logic                   in_valid;
    logic                   in_sof;
    logic                   in_eol;
    video_pkg::pixel_t      in_pixel;
    warp_pkg::warp_matrix_t coefs;
    video_pkg::out_beat_t   out_beat;
    logic                   out_valid;
    logic                   out_ready = 1'b0;

    logic [23:0] patterns [case_words * case_count];
    integer      seed = 32'hfee0_3975;

    // Beats taken from the output during the current case
    video_pkg::out_beat_t got_q[$];

    logic                 source_done = 1'b0;
    logic                 prev_stall = 1'b0;
    video_pkg::out_beat_t prev_beat = '0;
    logic                 timed_out = 1'b0;

    int pixel_errors = 0;
    int flag_errors = 0;
    int protocol_errors = 0;

    always #5 clock = ~clock;

    keystone_top u_dut (
        .clock     (clock),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_sof    (in_sof),
        .in_eol    (in_eol),
        .in_pixel  (in_pixel),
        .coefs     (coefs),
        .out_beat  (out_beat),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    //////////////////////////////
    // Output side
    //////////////////////////////

    // Random stalls, ready about half the time so the queue fills up
    always @(posedge clock) begin
        out_ready <= ($random(seed) & 1) != 0;
    end

    // Sampled mid-cycle, a transfer happens on the next rising edge
    always @(negedge clock) begin
        if (!reset) begin
            // Nothing may come out before the whole source frame is in
            assert (source_done || !out_valid) else begin
                $display("out_valid was raised before the source frame was complete");
                protocol_errors++;
            end
            // Stalled head beat must hold
            if (prev_stall) begin
                assert (out_valid && out_beat == prev_beat) else begin
                    $display("[ERROR] out_beat changed during a stall, expected %h got %h",
                             prev_beat, out_beat);
                    protocol_errors++;
                end
            end
            if (out_valid && out_ready) begin
                assert (got_q.size() < frame_size) else begin
                    $display("More beats arrived than one frame holds");
                    protocol_errors++;
                end
                got_q.push_back(out_beat);
            end
            prev_stall = out_valid && !out_ready;
            prev_beat  = out_beat;
        end
    end

    //////////////////////////////
    // Case steps
    //////////////////////////////

    // One source frame in raster order, coefficients with the first beat
    task automatic send_frame(input int base);
        for (int i = 0; i < frame_size; i++) begin
            @(posedge clock);
            if (i == 0) begin
                source_done = 1'b0;
                coefs.a <= patterns[base][15:0];
                coefs.b <= patterns[base + 1][15:0];
                coefs.c <= patterns[base + 2][15:0];
                coefs.d <= patterns[base + 3][15:0];
                coefs.e <= patterns[base + 4][15:0];
                coefs.f <= patterns[base + 5][15:0];
            end
            in_valid <= 1'b1;
            in_sof   <= (i == 0);
            in_eol   <= (i % video_pkg::frame_width) == (video_pkg::frame_width - 1);
            in_pixel <= patterns[base + 6 + i];
        end
        // Last beat is taken on this edge
        @(posedge clock);
        in_valid <= 1'b0;
        in_sof   <= 1'b0;
        in_eol   <= 1'b0;
        source_done = 1'b1;
    endtask

    // First result within 6 cycles of the last source beat
    task automatic check_first_valid(input int case_idx);
        int waited;
        waited = 0;
        while (!out_valid && waited < 6) begin
            @(negedge clock);
            waited++;
        end
        assert (out_valid) else begin
            $display("Case %0d: first output did not appear within 6 cycles", case_idx);
            protocol_errors++;
        end
    endtask

    task automatic collect_frame(input int case_idx);
        int waited;
        waited = 0;
        while (got_q.size() < frame_size && waited < 500) begin
            @(posedge clock);
            waited++;
        end
        if (got_q.size() < frame_size) begin
            $display("Case %0d: timed out with %0d of %0d output beats",
                     case_idx, got_q.size(), frame_size);
            protocol_errors++;
            timed_out = 1'b1;
        end else begin
            // Queue should now be empty with no extra beats behind
            @(negedge clock);
            waited = 0;
            while (out_valid && waited < 20) begin
                @(negedge clock);
                waited++;
            end
            assert (!out_valid && got_q.size() == frame_size) else begin
                $display("Case %0d: frame did not end with exactly %0d beats", case_idx,
                         frame_size);
                protocol_errors++;
            end
        end
    endtask

    // Pixels from the file, flags from the raster position
    task automatic compare_frame(input int case_idx, input int base);
        video_pkg::pixel_t exp_pixel;
        logic              exp_sof;
        logic              exp_eol;
        for (int i = 0; i < frame_size; i++) begin
            exp_pixel = patterns[base + 6 + frame_size + i];
            exp_sof   = (i == 0);
            exp_eol   = (i % video_pkg::frame_width) == (video_pkg::frame_width - 1);
            assert (got_q[i].pixel == exp_pixel) else begin
                $display("[ERROR] case %0d beat %0d out_beat.pixel expected %h got %h",
                         case_idx, i, exp_pixel, got_q[i].pixel);
                pixel_errors++;
            end
            assert (got_q[i].sof == exp_sof) else begin
                $display("[ERROR] case %0d beat %0d out_beat.sof expected %h got %h",
                         case_idx, i, exp_sof, got_q[i].sof);
                flag_errors++;
            end
            assert (got_q[i].eol == exp_eol) else begin
                $display("[ERROR] case %0d beat %0d out_beat.eol expected %h got %h",
                         case_idx, i, exp_eol, got_q[i].eol);
                flag_errors++;
            end
        end
    endtask

    task automatic run_case(input int case_idx);
        int base;
        base = case_idx * case_words;
        got_q.delete();
        send_frame(base);
        check_first_valid(case_idx);
        collect_frame(case_idx);
        if (!timed_out) begin
            compare_frame(case_idx, base);
        end
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        reset    <= 1'b1;
        in_valid <= 1'b0;
        in_sof   <= 1'b0;
        in_eol   <= 1'b0;
        in_pixel <= '0;
        coefs    <= '0;
        $readmemh("dv/keystone_patterns.hex", patterns);
        repeat (4) @(posedge clock);
        reset <= 1'b0;
        // Identity, shift with clipping, shear and scale
        for (int c = 0; c < case_count && !timed_out; c++) begin
            run_case(c);
        end
        $display("Error counts: pixel %0d, flag %0d, protocol %0d",
                 pixel_errors, flag_errors, protocol_errors);
        if (pixel_errors + flag_errors + protocol_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== dv/keystone_patterns.hex ====
// Three cases of 70 words: coefficients a b c d e f as signed Q8.8,
// then 32 source pixels and 32 expected output pixels in raster order, 24-bit RGB

// Case 0, identity
0100 0000 0000 0000 0100 0000
400000 410101 420202 430303 440404 450505 460606 470707
480808 490909 4A0A0A 4B0B0B 4C0C0C 4D0D0D 4E0E0E 4F0F0F
501010 511111 521212 531313 541414 551515 561616 571717
581818 591919 5A1A1A 5B1B1B 5C1C1C 5D1D1D 5E1E1E 5F1F1F
400000 410101 420202 430303 440404 450505 460606 470707
480808 490909 4A0A0A 4B0B0B 4C0C0C 4D0D0D 4E0E0E 4F0F0F
501010 511111 521212 531313 541414 551515 561616 571717
581818 591919 5A1A1A 5B1B1B 5C1C1C 5D1D1D 5E1E1E 5F1F1F

// Case 1, c = 2.5 and f = -1.0, source is x+3 and y-1
0100 0000 0280 0000 0100 FF00
800000 810101 820202 830303 840404 850505 860606 870707
880808 890909 8A0A0A 8B0B0B 8C0C0C 8D0D0D 8E0E0E 8F0F0F
901010 911111 921212 931313 941414 951515 961616 971717
981818 991919 9A1A1A 9B1B1B 9C1C1C 9D1D1D 9E1E1E 9F1F1F
000000 000000 000000 000000 000000 000000 000000 000000
830303 840404 850505 860606 870707 000000 000000 000000
8B0B0B 8C0C0C 8D0D0D 8E0E0E 8F0F0F 000000 000000 000000
931313 941414 951515 961616 971717 000000 000000 000000

// Case 2, b = 0.5 and e = 0.75
0100 0080 0000 0000 00C0 0000
C00000 C10101 C20202 C30303 C40404 C50505 C60606 C70707
C80808 C90909 CA0A0A CB0B0B CC0C0C CD0D0D CE0E0E CF0F0F
D01010 D11111 D21212 D31313 D41414 D51515 D61616 D71717
D81818 D91919 DA1A1A DB1B1B DC1C1C DD1D1D DE1E1E DF1F1F
C00000 C10101 C20202 C30303 C40404 C50505 C60606 C70707
C90909 CA0A0A CB0B0B CC0C0C CD0D0D CE0E0E CF0F0F 000000
D11111 D21212 D31313 D41414 D51515 D61616 D71717 000000
D21212 D31313 D41414 D51515 D61616 D71717 000000 000000

// ==== filelist.f ====
design/video_pkg.sv
design/warp_pkg.sv
design/frame_capture.sv
design/frame_store.sv
design/warp_engine.sv
design/output_queue.sv
design/keystone_top.sv
dv/tb_keystone.sv

// ==== Makefile ====
# Keystone corrector, Verilator flow

LOG = sim.log

.PHONY: all lint sim clean

all: sim

# Static checks on the RTL top level
lint:
	verilator --lint-only -Wall --timing -f filelist.f --top-module keystone_top

# Build and run the testbench, fail unless the pass line is in the log
sim:
	verilator --binary --timing --assert -Wno-fatal -f filelist.f \
		--top-module tb_keystone -Mdir obj_dir
	./obj_dir/Vtb_keystone | tee $(LOG)
	grep -qx "TEST OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
